// File: test/wb_stimulus.txt
# I op rs1 rs2 rd imm(hex) gap_ok | tag data(hex) write seq ; op 0 add 1 sub 2 xor 3 li 4 mul
# seq is the commit position in the group, -1 for none; M sets inorder, S suppress, D drains
M 0
I 3 0 0 1 00001234 1 0 00001234 1 0
I 3 0 0 2 00000056 1 1 00000056 1 1
I 3 0 0 3 ffff0001 1 2 ffff0001 1 2
I 3 0 0 4 00010003 1 3 00010003 1 3
D
I 0 1 2 5 00000000 1 4 0000128a 1 0
I 1 1 2 6 00000000 1 5 000011de 1 1
I 2 3 4 7 00000000 1 6 fffe0002 1 2
I 1 2 1 8 00000000 1 7 ffffee22 1 3
D
I 4 1 2 9 00000000 1 8 00061d78 1 0
I 4 3 4 10 00000000 1 9 fffe0003 1 1
D
I 4 1 1 11 00000000 1 10 014b5a90 1 1
I 0 2 2 12 00000000 0 11 000000ac 1 0
D
M 1
I 4 2 2 13 00000000 1 12 00001ce4 1 0
I 0 1 5 14 00000000 0 13 000024be 1 1
D
M 0
I 3 0 0 0 0000dead 1 14 0000dead 0 0
I 0 1 2 0 00000000 1 15 0000128a 0 1
D
S 1
I 3 0 0 15 0000beef 1 0 0000beef 1 -1
I 4 1 2 15 00000000 1 1 00061d78 1 -1
D
S 0
I 0 15 0 15 00000000 1 2 00000000 1 0
D
I 4 1 2 9 00000000 1 3 00061d78 1 0
I 4 3 4 10 00000000 0 4 fffe0003 1 1
I 4 1 1 11 00000000 0 5 014b5a90 1 2
I 4 2 2 12 00000000 0 6 00001ce4 1 3
I 4 2 1 13 00000000 0 7 00061d78 1 4
D

// File: sources.f
hw/wb_config_pkg.sv
hw/wb_types_pkg.sv
hw/inflight_queue.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/write_back.sv
hw/register_file.sv
hw/wb_pipeline_top.sv
test/wb_pipeline_assert.sv
test/tb_wb_pipeline.sv

// File: Makefile
TOP := tb_wb_pipeline
LOG := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

sim: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_wb_pipeline.sv
/*
 * Write-back pipeline testbench
 * Replays issue records from the stimulus file and checks every completion
 */
module tb_wb_pipeline;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;
    localparam int SETTLE_CYCLES = 6;

    logic                  clk;
    logic                  reset;
    logic                  inorder;
    logic                  suppress;
    logic                  issue_valid;
    wb_types_pkg::issue_t  issue;
    logic                  issue_ready;
    logic                  commit_valid;
    wb_types_pkg::commit_t commit;

    int cycle = 0;
    int errors = 0;
    int timeouts = 0;
    int issues = 0;

    // Expected completions of the group in flight
    int          exp_tag [$];
    int          exp_rd [$];
    int          exp_write [$];
    int          exp_seq [$];
    int          exp_start [$];
    int          exp_mul [$];
    logic [31:0] exp_data [$];

    // Completions seen on the commit port, in arrival order
    int          got_tag [$];
    int          got_rd [$];
    int          got_write [$];
    int          got_cycle [$];
    logic [31:0] got_data [$];

    wb_pipeline_top u_wb_pipeline_top (
        .clk(clk), .reset(reset), .inorder(inorder), .suppress(suppress),
        .issue_valid(issue_valid), .issue(issue), .issue_ready(issue_ready),
        .commit_valid(commit_valid), .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Commit outputs come straight from registers, so the falling edge is safe
    always @(negedge clk) begin
        if (!reset && commit_valid) begin
            got_tag.push_back(int'(commit.tag));
            got_rd.push_back(int'(commit.rd));
            got_write.push_back(int'(commit.write));
            got_data.push_back(commit.data);
            got_cycle.push_back(cycle);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    // Presents one issue from a falling edge and returns on the falling edge after it
    task automatic send_issue(input int op, input int rs1, input int rs2, input int rd,
                              input logic [31:0] imm, input int gap_ok,
                              output int start_cycle);
        int gap;
        int tries;
        gap = gap_ok ? $urandom_range(2, 0) : 0;
        tries = 0;
        start_cycle = 0;
        repeat (gap) @(negedge clk);
        issue.op = wb_types_pkg::unit_op_t'(op[2:0]);
        issue.rs1 = rs1[3:0];
        issue.rs2 = rs2[3:0];
        issue.rd = rd[3:0];
        issue.imm = imm;
        issue_valid = 1'b1;
        forever begin
            #1;
            if (issue_ready) begin
                break;
            end
            tries++;
            if (tries > WAIT_LIMIT) begin
                $display("Timeout: issue_ready stayed low for issue %0d", issues);
                timeouts++;
                issue_valid = 1'b0;
                return;
            end
            @(negedge clk);
        end
        start_cycle = cycle;
        issues++;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    // Waits for the group's completions, lets stray ones show up, then compares
    task automatic drain_group();
        int expected_count;
        int tries;
        int idx;
        expected_count = 0;
        tries = 0;
        foreach (exp_seq[i]) begin
            if (exp_seq[i] >= 0) begin
                expected_count++;
            end
        end
        forever begin
            if (got_tag.size() >= expected_count) begin
                break;
            end
            tries++;
            if (tries > WAIT_LIMIT) begin
                $display("Timeout: only %0d of %0d completions arrived",
                         got_tag.size(), expected_count);
                timeouts++;
                break;
            end
            @(negedge clk);
            #1;
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
        #1;
        check_value("commit_count", got_tag.size(), expected_count);
        foreach (exp_seq[i]) begin
            idx = exp_seq[i];
            if (idx < 0 || idx >= got_tag.size()) begin
                continue;
            end
            check_value("commit.tag", got_tag[idx], exp_tag[i]);
            check_value("commit.rd", got_rd[idx], exp_rd[i]);
            check_value("commit.data", got_data[idx], exp_data[i]);
            check_value("commit.write", got_write[idx], exp_write[i]);
            // Counted from the cycle the issue was presented
            if (exp_mul[i] != 0 && got_cycle[idx] - exp_start[i] <
                wb_config_pkg::MUL_LATENCY) begin
                $display("Multiply with tag %0d completed after only %0d cycles",
                         exp_tag[i], got_cycle[idx] - exp_start[i]);
                errors++;
            end
        end
        exp_tag.delete();
        exp_rd.delete();
        exp_write.delete();
        exp_seq.delete();
        exp_start.delete();
        exp_mul.delete();
        exp_data.delete();
        got_tag.delete();
        got_rd.delete();
        got_write.delete();
        got_cycle.delete();
        got_data.delete();
    endtask

    initial begin
        int          fd;
        int          kind;
        int          op;
        int          rs1;
        int          rs2;
        int          rd;
        int          gap_ok;
        int          tag;
        int          wr;
        int          seq;
        int          level;
        int          start;
        logic [31:0] imm;
        logic [31:0] data;
        string       line;
        void'($urandom(25268));
        reset = 1'b1;
        inorder = 1'b0;
        suppress = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Out of reset the pipeline is empty and takes an issue at once
        check_value("issue_ready", issue_ready, 1);
        check_value("commit_valid", commit_valid, 0);
        fd = $fopen("test/wb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/wb_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 1) begin
                    continue;
                end
                kind = int'(line.getc(0));
                if (kind == "I") begin
                    void'($sscanf(line, "I %d %d %d %d %h %d %d %h %d %d", op, rs1, rs2,
                                  rd, imm, gap_ok, tag, data, wr, seq));
                    send_issue(op, rs1, rs2, rd, imm, gap_ok, start);
                    exp_tag.push_back(tag);
                    exp_rd.push_back(rd);
                    exp_data.push_back(data);
                    exp_write.push_back(wr);
                    exp_seq.push_back(seq);
                    exp_start.push_back(start);
                    exp_mul.push_back(op == 4 ? 1 : 0);
                end else if (kind == "M") begin
                    void'($sscanf(line, "M %d", level));
                    inorder = level[0];
                end else if (kind == "S") begin
                    void'($sscanf(line, "S %d", level));
                    suppress = level[0];
                end else if (kind == "D") begin
                    drain_group();
                end
            end
            $fclose(fd);
        end
        $display("Run finished: %0d issues, %0d errors, %0d timeouts", issues, errors, timeouts);
        if (errors == 0 && timeouts == 0 && issues > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: test/wb_pipeline_assert.sv
/*
 * Write-back checker
 * Concurrent properties on grants and completions of the controller
 */
module wb_pipeline_assert (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   suppress,
    input  logic [wb_config_pkg::NUM_WB_UNITS-1:0] accepted,
    input  logic                                   commit_valid,
    input  wb_types_pkg::commit_t                  commit
);

    timeunit 1ns;
    timeprecision 100ps;

    // Only one unit is granted per cycle
    accepted_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(accepted))
        else $error("accepted grants more than one unit");

    // A granted unit drops its done flag at once, so one instruction never completes twice
    no_repeated_tag: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && $past(commit_valid)) |-> (commit.tag != $past(commit.tag)))
        else $error("same tag completed on two consecutive cycles");

    // The selection cycle is the one before the completion pulse
    no_commit_when_suppressed: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> !$past(suppress))
        else $error("completion pulsed although suppress was high at selection");

    // Register 0 is never written
    write_needs_rd: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && commit.write) |-> (commit.rd != '0))
        else $error("register write flagged for register 0");

endmodule

bind write_back wb_pipeline_assert u_wb_assert (
    .clk(clk),
    .reset(reset),
    .suppress(suppress),
    .accepted(accepted),
    .commit_valid(commit_valid),
    .commit(commit)
);

// File: hw/wb_pipeline_top.sv
/*
 * Write-back pipeline top level
 * Dispatches decoded issues to the ALU or multiplier and commits through write-back
 */
module wb_pipeline_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inorder,
    input  logic                   suppress,
    input  logic                   issue_valid,
    input  wb_types_pkg::issue_t   issue,
    output logic                   issue_ready,
    output logic                   commit_valid,
    output wb_types_pkg::commit_t  commit
);

    wb_types_pkg::unit_id_t                         issue_unit;
    wb_types_pkg::iq_entry_t                        new_entry;
    wb_types_pkg::iq_entry_t                        iq_entries [wb_config_pkg::IQ_DEPTH];
    wb_types_pkg::unit_result_t                     unit_results [wb_config_pkg::NUM_WB_UNITS];
    logic [wb_config_pkg::IQ_DEPTH-1:0]             iq_valid;
    logic [wb_config_pkg::IQ_DEPTH-1:0]             pop;
    logic [wb_config_pkg::NUM_WB_UNITS-1:0]         accepted;
    logic [wb_config_pkg::TAG_W-1:0]                new_tag;
    logic [wb_config_pkg::XLEN-1:0]                 rdata1;
    logic [wb_config_pkg::XLEN-1:0]                 rdata2;
    logic                                           iq_full;
    logic                                           take_new;
    logic                                           new_issue;
    logic                                           alu_busy;
    logic                                           mul_stall;

    assign issue_unit = (issue.op == wb_types_pkg::OP_MUL) ? wb_types_pkg::UNIT_MUL
                                                          : wb_types_pkg::UNIT_ALU;

    // Ready only looks at registered state, which keeps issue free of loops
    assign issue_ready = ~iq_full & ((issue_unit == wb_types_pkg::UNIT_ALU) ? ~alu_busy
                                                                            : ~mul_stall);
    assign new_issue = issue_valid & issue_ready;

    assign new_entry.tag = new_tag;
    assign new_entry.unit = issue_unit;
    assign new_entry.rd = issue.rd;
    assign new_entry.rd_nonzero = (issue.rd != '0);

    inflight_queue u_iq (
        .clk(clk), .reset(reset),
        .push(new_issue), .push_entry(new_entry), .take_new(take_new), .pop(pop),
        .valid(iq_valid), .entries(iq_entries), .new_tag(new_tag), .full(iq_full)
    );

    alu_unit u_alu (
        .clk(clk), .reset(reset),
        .start(new_issue & (issue_unit == wb_types_pkg::UNIT_ALU)),
        .op(issue.op), .a(rdata1), .b(rdata2), .imm(issue.imm),
        .accepted(accepted[wb_types_pkg::UNIT_ALU]),
        .result(unit_results[wb_types_pkg::UNIT_ALU]), .busy(alu_busy)
    );

    mul_unit u_mul (
        .clk(clk), .reset(reset),
        .start(new_issue & (issue_unit == wb_types_pkg::UNIT_MUL)),
        .a(rdata1), .b(rdata2),
        .accepted(accepted[wb_types_pkg::UNIT_MUL]),
        .result(unit_results[wb_types_pkg::UNIT_MUL]), .stall(mul_stall)
    );

    write_back u_wb (
        .clk(clk), .reset(reset), .inorder(inorder), .suppress(suppress),
        .iq_valid(iq_valid), .iq_entries(iq_entries),
        .new_issue(new_issue), .new_entry(new_entry), .unit_results(unit_results),
        .pop(pop), .take_new(take_new), .accepted(accepted),
        .commit_valid(commit_valid), .commit(commit)
    );

    // commit.write already folds in suppress and the register 0 check
    register_file u_rf (
        .clk(clk), .reset(reset),
        .rs1(issue.rs1), .rs2(issue.rs2), .rdata1(rdata1), .rdata2(rdata2),
        .write_valid(commit_valid & commit.write),
        .write_addr(commit.rd), .write_data(commit.data)
    );

endmodule

// File: hw/register_file.sv
/*
 * Register file
 * Two combinational read ports and one write port, register 0 reads zero
 */
module register_file (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [wb_config_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [wb_config_pkg::REG_ADDR_W-1:0] rs2,
    output logic [wb_config_pkg::XLEN-1:0]       rdata1,
    output logic [wb_config_pkg::XLEN-1:0]       rdata2,
    input  logic                                 write_valid,
    input  logic [wb_config_pkg::REG_ADDR_W-1:0] write_addr,
    input  logic [wb_config_pkg::XLEN-1:0]       write_data
);

    logic [wb_config_pkg::XLEN-1:0] regs [wb_config_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < wb_config_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_valid && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // No bypass, a dependent issue waits until its producer has committed
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hw/write_back.sv
/*
 * Write-back controller
 * Picks the completing instruction each cycle, grants its unit and
 * registers the register-file write and the completion with its tag
 */
module write_back (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                inorder,
    input  logic                                suppress,
    input  logic [wb_config_pkg::IQ_DEPTH-1:0]  iq_valid,
    input  wb_types_pkg::iq_entry_t             iq_entries [wb_config_pkg::IQ_DEPTH],
    input  logic                                new_issue,
    input  wb_types_pkg::iq_entry_t             new_entry,
    input  wb_types_pkg::unit_result_t          unit_results [wb_config_pkg::NUM_WB_UNITS],
    output logic [wb_config_pkg::IQ_DEPTH-1:0]  pop,
    output logic                                take_new,
    output logic [wb_config_pkg::NUM_WB_UNITS-1:0] accepted,
    output logic                                commit_valid,
    output wb_types_pkg::commit_t               commit
);

    logic [wb_config_pkg::IQ_DEPTH-1:0]         done_array;
    logic [$clog2(wb_config_pkg::IQ_DEPTH)-1:0] idx_oldest_done;
    logic [$clog2(wb_config_pkg::IQ_DEPTH)-1:0] iq_index;
    logic                                       entry_found;
    logic                                       queue_done;
    logic                                       new_done;
    logic                                       selected;
    wb_types_pkg::iq_entry_t                    sel_entry;
    logic [wb_config_pkg::NUM_WB_UNITS-1:0]     new_accepted;

    wb_types_pkg::unit_id_t                     unit_r;
    logic [wb_config_pkg::TAG_W-1:0]            tag_r;
    logic [wb_config_pkg::REG_ADDR_W-1:0]       rd_r;
    logic                                       write_r;

    // Queue slot 0 is the oldest, so scanning downward leaves the oldest done entry
    always_comb begin
        idx_oldest_done = '0;
        for (int i = wb_config_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
            done_array[i] = iq_valid[i] & unit_results[iq_entries[i].unit].done_next;
            if (done_array[i]) begin
                idx_oldest_done = i[$clog2(wb_config_pkg::IQ_DEPTH)-1:0];
            end
        end

        // In-order mode blocks on the oldest entry even when younger ones are done
        entry_found = inorder ? iq_valid[0] : |done_array;
        iq_index = inorder ? '0 : idx_oldest_done;
        queue_done = inorder ? done_array[0] : |done_array;

        pop = '0;
        pop[iq_index] = queue_done;
    end

    // A fresh issue completes directly only when the queue offers nothing
    always_comb begin
        new_done = new_issue & unit_results[new_entry.unit].done_first_cycle;
        take_new = ~entry_found & new_done;
        selected = queue_done | take_new;
        sel_entry = entry_found ? iq_entries[iq_index] : new_entry;

        new_accepted = '0;
        new_accepted[sel_entry.unit] = selected;
    end

    // Suppress drops the completion but the unit is still granted and the entry popped
    always_ff @(posedge clk) begin
        if (reset) begin
            accepted <= '0;
            commit_valid <= 1'b0;
            write_r <= 1'b0;
        end else begin
            accepted <= new_accepted;
            commit_valid <= selected & ~suppress;
            write_r <= selected & sel_entry.rd_nonzero & ~suppress;
        end
    end

    always_ff @(posedge clk) begin
        unit_r <= sel_entry.unit;
        tag_r <= sel_entry.tag;
        rd_r <= sel_entry.rd;
    end

    // The granted unit presents its data on the cycle after selection
    assign commit.tag = tag_r;
    assign commit.rd = rd_r;
    assign commit.data = unit_results[unit_r].data;
    assign commit.write = write_r;

endmodule

// File: hw/mul_unit.sv
/*
 * Pipelined multiplier
 * Three stages keeping the low word of the product, stalls while unaccepted
 */
module mul_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic [wb_config_pkg::XLEN-1:0]    a,
    input  logic [wb_config_pkg::XLEN-1:0]    b,
    input  logic                              accepted,
    output wb_types_pkg::unit_result_t        result,
    output logic                              stall
);

    localparam int LAST = wb_config_pkg::MUL_LATENCY - 1;

    wb_types_pkg::mul_stage_t       stage [wb_config_pkg::MUL_LATENCY];
    logic [wb_config_pkg::XLEN-1:0] op_a;
    logic [wb_config_pkg::XLEN-1:0] op_b;
    logic [wb_config_pkg::XLEN-1:0] product [1:LAST];
    logic                           advance;

    // The whole pipe moves together once the last stage is free or leaving
    assign advance = (stage[LAST] == wb_types_pkg::STAGE_EMPTY) | accepted;
    assign stall = ~advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < wb_config_pkg::MUL_LATENCY; i++) begin
                stage[i] <= wb_types_pkg::STAGE_EMPTY;
            end
        end else if (advance) begin
            stage[0] <= start ? wb_types_pkg::STAGE_FULL : wb_types_pkg::STAGE_EMPTY;
            for (int i = 1; i < wb_config_pkg::MUL_LATENCY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // Stage 0 registers the operands, stage 1 multiplies, the last stage holds
    always_ff @(posedge clk) begin
        if (advance) begin
            op_a <= a;
            op_b <= b;
            product[1] <= op_a * op_b;
            for (int i = 2; i <= LAST; i++) begin
                product[i] <= product[i-1];
            end
        end
    end

    // Data is valid next cycle if the last stage stays full, or refills from behind
    assign result.done_next = advance ? (stage[LAST-1] == wb_types_pkg::STAGE_FULL)
                                      : (stage[LAST] == wb_types_pkg::STAGE_FULL);
    assign result.done_first_cycle = 1'b0;
    assign result.data = product[LAST];

endmodule

// File: hw/alu_unit.sv
/*
 * Single-cycle ALU
 * Add, subtract, xor and load-immediate with a one-entry result hold register
 */
module alu_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  wb_types_pkg::unit_op_t            op,
    input  logic [wb_config_pkg::XLEN-1:0]    a,
    input  logic [wb_config_pkg::XLEN-1:0]    b,
    input  logic [wb_config_pkg::XLEN-1:0]    imm,
    input  logic                              accepted,
    output wb_types_pkg::unit_result_t        result,
    output logic                              busy
);

    logic [wb_config_pkg::XLEN-1:0] value;
    logic [wb_config_pkg::XLEN-1:0] hold_data;
    logic                           hold_valid;

    always_comb begin
        case (op)
            wb_types_pkg::OP_ADD: value = a + b;
            wb_types_pkg::OP_SUB: value = a - b;
            wb_types_pkg::OP_XOR: value = a ^ b;
            wb_types_pkg::OP_LI:  value = imm;
            default:              value = '0;
        endcase
    end

    // The write-back stage reads data one cycle after it selects, so results
    // are always served from the hold register
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (start) begin
            hold_valid <= 1'b1;
        end else if (accepted) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            hold_data <= value;
        end
    end

    // An accept this cycle frees the hold register for a new issue
    assign busy = hold_valid & ~accepted;

    assign result.done_first_cycle = start;
    assign result.done_next = hold_valid & ~accepted;
    assign result.data = hold_data;

endmodule

// File: hw/inflight_queue.sv
/*
 * Inflight queue
 * Tracks issued instructions oldest-first and hands out a wrapping tag per issue
 */
module inflight_queue (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                push,
    input  wb_types_pkg::iq_entry_t             push_entry,
    input  logic                                take_new,
    input  logic [wb_config_pkg::IQ_DEPTH-1:0]  pop,
    output logic [wb_config_pkg::IQ_DEPTH-1:0]  valid,
    output wb_types_pkg::iq_entry_t             entries [wb_config_pkg::IQ_DEPTH],
    output logic [wb_config_pkg::TAG_W-1:0]     new_tag,
    output logic                                full
);

    logic [wb_config_pkg::IQ_DEPTH-1:0] next_valid;
    wb_types_pkg::iq_entry_t            next_entries [wb_config_pkg::IQ_DEPTH];
    int                                 fill;

    // Slot 0 is always the oldest entry and valid bits stay contiguous from 0
    always_comb begin
        fill = 0;
        next_valid = '0;
        next_entries = entries;
        // Survivors slide down over any popped slot, keeping their age order
        for (int i = 0; i < wb_config_pkg::IQ_DEPTH; i++) begin
            if (valid[i] && !pop[i]) begin
                next_entries[fill] = entries[i];
                next_valid[fill] = 1'b1;
                fill++;
            end
        end
        // An issue completing directly is never stored
        if (push && !take_new && fill < wb_config_pkg::IQ_DEPTH) begin
            next_entries[fill] = push_entry;
            next_valid[fill] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            new_tag <= '0;
        end else begin
            valid <= next_valid;
            // Each issue uses a tag, stored or not
            if (push) begin
                new_tag <= new_tag + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        entries <= next_entries;
    end

    // Compaction means the top slot is only occupied when every slot is
    assign full = valid[wb_config_pkg::IQ_DEPTH-1];

endmodule

// File: hw/wb_types_pkg.sv
/*
 * Write-back pipeline types
 * Opcodes, unit identifiers and the structs passed between the pipeline blocks
 */
package wb_types_pkg;

    // Decoded unit operation, everything except OP_MUL runs on the ALU
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_LI,
        OP_MUL
    } unit_op_t;

    // Writing units, the value doubles as the index into the result array
    typedef enum logic [wb_config_pkg::UNIT_ID_W-1:0] {
        UNIT_ALU,
        UNIT_MUL
    } unit_id_t;

    // Occupancy of one multiplier stage
    typedef enum logic {
        STAGE_EMPTY,
        STAGE_FULL
    } mul_stage_t;

    typedef struct packed {
        unit_op_t                            op;
        logic [wb_config_pkg::REG_ADDR_W-1:0] rs1;
        logic [wb_config_pkg::REG_ADDR_W-1:0] rs2;
        logic [wb_config_pkg::REG_ADDR_W-1:0] rd;
        logic [wb_config_pkg::XLEN-1:0]       imm;
    } issue_t;

    // rd_nonzero is kept so the controller needs no compare on the select path
    typedef struct packed {
        logic [wb_config_pkg::TAG_W-1:0]      tag;
        unit_id_t                             unit;
        logic [wb_config_pkg::REG_ADDR_W-1:0] rd;
        logic                                 rd_nonzero;
    } iq_entry_t;

    // done_next promises valid data on the following cycle
    typedef struct packed {
        logic                           done_first_cycle;
        logic                           done_next;
        logic [wb_config_pkg::XLEN-1:0] data;
    } unit_result_t;

    typedef struct packed {
        logic [wb_config_pkg::TAG_W-1:0]      tag;
        logic [wb_config_pkg::REG_ADDR_W-1:0] rd;
        logic [wb_config_pkg::XLEN-1:0]       data;
        logic                                 write;
    } commit_t;

endpackage

// File: hw/wb_config_pkg.sv
/*
 * Write-back pipeline sizing
 * Widths and depths shared by the queue, the execution units and the controller
 */
package wb_config_pkg;

    // Data path width of every operand, immediate and result
    localparam int XLEN = 32;

    // Architectural register count, register 0 is hardwired to zero
    localparam int NUM_REGS = 16;

    // Units that can write back: the ALU and the multiplier
    localparam int NUM_WB_UNITS = 2;

    // Number of issued instructions the inflight queue can track
    localparam int IQ_DEPTH = 4;

    // Cycles from a multiply issue to its commit
    localparam int MUL_LATENCY = 3;

    localparam int REG_ADDR_W = $clog2(NUM_REGS);

    // Two spare tag bits so a wrapped tag never aliases one still in flight
    localparam int TAG_W = $clog2(IQ_DEPTH) + 2;

    localparam int UNIT_ID_W = $clog2(NUM_WB_UNITS);

endpackage
